//--- cal_config.svh
// ====================================================================
// ADC calibration configuration
// Build-time sizes shared by the calibration datapath, the APB
// register bank and the testbench
// ====================================================================
`ifndef CAL_CONFIG_SVH
`define CAL_CONFIG_SVH

// Number of multiplexed ADC channels carried on the sample stream
`define CAL_CHANNELS 4

// Width of a raw or calibrated sample, also the width of an offset
`define CAL_SAMPLE_WIDTH 16

// Width of a per-channel left-shift amount, 4 bits gives shifts of 0 to 15
`define CAL_SHIFT_WIDTH 4

// Width of the user tag that rides along with each sample
`define CAL_USER_WIDTH 8

// APB address width, enough for the control, mask, offset and shift windows
`define CAL_APB_ADDR_WIDTH 8

`endif

//--- cal_regs_pkg.sv
// ====================================================================
// Calibration register map
// APB bus vector types, register offsets and the decoded register
// class used by the calibration register bank
// ====================================================================
package cal_regs_pkg;

`include "cal_config.svh"

    // APB3 data bus is always one 32-bit word
    localparam int APB_DATA_WIDTH = 32;

    typedef logic [`CAL_APB_ADDR_WIDTH-1:0] apb_addr_t;
    typedef logic [APB_DATA_WIDTH-1:0] apb_data_t;

    // Global control, bit 0 enables the per-channel left shift
    localparam apb_addr_t REG_CTRL = 'h00;

    // Bit n set means channel n produces signed output
    localparam apb_addr_t REG_SIGNED_MASK = 'h04;

    // Per-channel tables, one word per channel at base plus 4n
    localparam apb_addr_t REG_OFFSET_BASE = 'h10;
    localparam apb_addr_t REG_SHIFT_BASE = 'h20;

    // Size in bytes of each per-channel table window
    localparam int REG_WINDOW = 16;

    // Address class after decoding, sel_none marks an unmapped access
    typedef enum logic [2:0] {
        sel_ctrl,
        sel_mask,
        sel_offset,
        sel_shift,
        sel_none
    } reg_sel_e;

endpackage

//--- cal_stream_pkg.sv
// ====================================================================
// Calibration stream types
// Vector types for the samples, channel numbers, user tags and shift
// amounts that move through the calibration datapath
// ====================================================================
package cal_stream_pkg;

`include "cal_config.svh"

    // Width of the dest field, kept at one bit or more so a single
    // channel build still has a legal index
    localparam int CHANNEL_WIDTH = (`CAL_CHANNELS > 1) ? $clog2(`CAL_CHANNELS) : 1;

    // A raw ADC sample, a calibrated sample or a per-channel offset
    typedef logic signed [`CAL_SAMPLE_WIDTH-1:0] sample_t;

    // Channel number carried in the dest field of the stream
    typedef logic [CHANNEL_WIDTH-1:0] channel_t;

    // Opaque tag that passes through the datapath unchanged
    typedef logic [`CAL_USER_WIDTH-1:0] user_t;

    // Left-shift amount applied after the offset correction
    typedef logic [`CAL_SHIFT_WIDTH-1:0] shift_t;

endpackage

//--- calibration.sv
// ====================================================================
// Calibration datapath
// Adds a per-channel offset with saturation to each stream sample,
// optionally shifts it left, and registers the result with one cycle
// of latency while passing dest and user through
// ====================================================================
`timescale 1ns/1ps

`include "cal_config.svh"

module calibration
    import cal_stream_pkg::*;
(
    input  logic                        clock,
    input  logic                        reset,

    input  logic                        in_valid,
    input  sample_t                     in_data,
    input  channel_t                    in_dest,
    input  user_t                       in_user,
    output logic                        in_ready,

    input  logic                        out_ready,
    output logic                        out_valid,
    output sample_t                     out_data,
    output channel_t                    out_dest,
    output user_t                       out_user,

    input  sample_t [`CAL_CHANNELS-1:0] offset_table,
    input  shift_t  [`CAL_CHANNELS-1:0] shift_table,
    input  logic    [`CAL_CHANNELS-1:0] signed_mask,
    input  logic                        shift_enable
);

    // Settings picked for the channel of the incoming sample
    sample_t  channel_offset;
    shift_t   channel_shift;
    logic     channel_signed;

    sample_t  clamped_sum;
    sample_t  calibrated;
    logic     transfer;

    // The single output register frees up whenever downstream takes data,
    // so ready flows straight through, reset included
    assign in_ready = out_ready;

    // A sample moves on every edge where both sides agree
    assign transfer = in_valid && out_ready;

    // Per-channel lookups indexed by the dest field
    assign channel_offset = offset_table[in_dest];
    assign channel_shift = shift_table[in_dest];
    assign channel_signed = signed_mask[in_dest];

    saturating_adder offset_adder (
        .a           (in_data),
        .b           (channel_offset),
        .signed_mode (channel_signed),
        .sum         (clamped_sum)
    );

    // The shift keeps only the low sample bits, the overflow is discarded
    assign calibrated = shift_enable ? sample_t'(clamped_sum << channel_shift) : clamped_sum;

    // Valid is high for exactly the cycle after an accepting edge
    always_ff @(posedge clock) begin
        if (!reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= transfer;
        end
    end

    // Payload only loads on a transfer and is qualified by out_valid
    always_ff @(posedge clock) begin
        if (transfer) begin
            out_data <= calibrated;
            out_dest <= in_dest;
            out_user <= in_user;
        end
    end

endmodule

//--- calibration_registers.sv
// ====================================================================
// Calibration register bank
// APB3 slave holding the shift enable, the signed output mask and the
// per-channel offset and shift tables used by the datapath
// ====================================================================
`timescale 1ns/1ps

`include "cal_config.svh"

module calibration_registers
    import cal_stream_pkg::*, cal_regs_pkg::*;
(
    input  logic                        clock,
    input  logic                        reset,

    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  apb_addr_t                   paddr,
    input  apb_data_t                   pwdata,
    output apb_data_t                   prdata,
    output logic                        pready,
    output logic                        pslverr,

    output sample_t [`CAL_CHANNELS-1:0] offset_table,
    output shift_t  [`CAL_CHANNELS-1:0] shift_table,
    output logic    [`CAL_CHANNELS-1:0] signed_mask,
    output logic                        shift_enable
);

    localparam int W = `CAL_SAMPLE_WIDTH;

    reg_sel_e  reg_sel;
    apb_addr_t slot;
    channel_t  reg_index;
    sample_t   offset_value;
    apb_data_t read_data;
    logic      setup_phase;
    logic      write_en;

    // Every access completes in one access cycle
    assign pready = 1'b1;

    assign setup_phase = psel && !penable;
    assign write_en = psel && penable && pwrite && (reg_sel != sel_none);

    // Address decode into a register class and a table slot
    always_comb begin
        reg_sel = sel_none;
        slot = '0;
        // Only word aligned addresses are mapped
        if (paddr[1:0] == 2'b00) begin
            if (paddr == REG_CTRL) begin
                reg_sel = sel_ctrl;
            end else if (paddr == REG_SIGNED_MASK) begin
                reg_sel = sel_mask;
            end else if (paddr >= REG_OFFSET_BASE && paddr < REG_OFFSET_BASE + REG_WINDOW) begin
                reg_sel = sel_offset;
                slot = (paddr - REG_OFFSET_BASE) >> 2;
            end else if (paddr >= REG_SHIFT_BASE && paddr < REG_SHIFT_BASE + REG_WINDOW) begin
                reg_sel = sel_shift;
                slot = (paddr - REG_SHIFT_BASE) >> 2;
            end
        end
        // Table slots past the last channel are treated as holes
        if (slot >= `CAL_CHANNELS) begin
            reg_sel = sel_none;
        end
    end

    assign reg_index = slot[CHANNEL_WIDTH-1:0];
    assign offset_value = offset_table[reg_index];

    // Read mux, offsets come back sign extended to the full word
    always_comb begin
        case (reg_sel)
            sel_ctrl:   read_data = apb_data_t'(shift_enable);
            sel_mask:   read_data = apb_data_t'(signed_mask);
            sel_offset: read_data = {{(APB_DATA_WIDTH-W){offset_value[W-1]}}, offset_value};
            sel_shift:  read_data = apb_data_t'(shift_table[reg_index]);
            default:    read_data = '0;
        endcase
    end

    // Writes land on the edge that closes the access phase
    always_ff @(posedge clock) begin
        if (!reset) begin
            shift_enable <= 1'b0;
            signed_mask <= '1;
            offset_table <= '0;
            shift_table <= '0;
        end else if (write_en) begin
            case (reg_sel)
                sel_ctrl:   shift_enable <= pwdata[0];
                sel_mask:   signed_mask <= pwdata[`CAL_CHANNELS-1:0];
                sel_offset: offset_table[reg_index] <= pwdata[W-1:0];
                sel_shift:  shift_table[reg_index] <= pwdata[`CAL_SHIFT_WIDTH-1:0];
                default:    shift_enable <= shift_enable;
            endcase
        end
    end

    // Read data and error are captured at the end of the setup phase
    // so both are stable for the whole access phase
    always_ff @(posedge clock) begin
        if (!reset) begin
            prdata <= '0;
            pslverr <= 1'b0;
        end else begin
            pslverr <= setup_phase && (reg_sel == sel_none);
            if (setup_phase && !pwrite) begin
                prdata <= read_data;
            end
        end
    end

endmodule

//--- calibration_top.sv
// ====================================================================
// ADC calibration subsystem
// Joins the APB register bank to the stream calibration datapath,
// which reads the current per-channel settings directly
// ====================================================================
`timescale 1ns/1ps

`include "cal_config.svh"

module calibration_top
    import cal_stream_pkg::*, cal_regs_pkg::*;
(
    input  logic      clock,
    input  logic      reset,

    // APB3 configuration port
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  apb_addr_t paddr,
    input  apb_data_t pwdata,
    output apb_data_t prdata,
    output logic      pready,
    output logic      pslverr,

    // Raw sample stream
    input  logic      in_valid,
    input  sample_t   in_data,
    input  channel_t  in_dest,
    input  user_t     in_user,
    output logic      in_ready,

    // Calibrated sample stream
    output logic      out_valid,
    output sample_t   out_data,
    output channel_t  out_dest,
    output user_t     out_user,
    input  logic      out_ready
);

    // Settings from the register bank to the datapath
    sample_t [`CAL_CHANNELS-1:0] offset_table;
    shift_t  [`CAL_CHANNELS-1:0] shift_table;
    logic    [`CAL_CHANNELS-1:0] signed_mask;
    logic                        shift_enable;

    calibration_registers i_registers (
        .clock        (clock),
        .reset        (reset),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .offset_table (offset_table),
        .shift_table  (shift_table),
        .signed_mask  (signed_mask),
        .shift_enable (shift_enable)
    );

    calibration i_calibration (
        .clock        (clock),
        .reset        (reset),
        .in_valid     (in_valid),
        .in_data      (in_data),
        .in_dest      (in_dest),
        .in_user      (in_user),
        .in_ready     (in_ready),
        .out_ready    (out_ready),
        .out_valid    (out_valid),
        .out_data     (out_data),
        .out_dest     (out_dest),
        .out_user     (out_user),
        .offset_table (offset_table),
        .shift_table  (shift_table),
        .signed_mask  (signed_mask),
        .shift_enable (shift_enable)
    );

endmodule

//--- files.f
+incdir+.
cal_stream_pkg.sv
cal_regs_pkg.sv
saturating_adder.sv
calibration.sv
calibration_registers.sv
calibration_top.sv
tb_calibration.sv

//--- run_sim.sh
#!/bin/sh
# Builds the calibration testbench with Verilator and runs it.
# The exit status is 0 only when the run prints the pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
    --top-module tb_calibration \
    -f files.f \
    -o tb_calibration_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/tb_calibration_sim)
sim_status=$?
echo "$sim_output"

if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -qF "*** TEST PASSED ***"; then
    exit 0
fi

echo "Pass message not found in simulation output"
exit 1

//--- saturating_adder.sv
// ====================================================================
// Saturating adder
// Adds two signed samples and clamps the sum to the sample range, with
// a lower limit of either the most negative value or zero
// ====================================================================
`timescale 1ns/1ps

`include "cal_config.svh"

module saturating_adder
    import cal_stream_pkg::*;
(
    input  sample_t a,
    input  sample_t b,
    input  logic    signed_mode,
    output sample_t sum
);

    localparam int W = `CAL_SAMPLE_WIDTH;

    // One guard bit above the sample keeps the raw sum free of overflow
    logic signed [W:0] wide_sum;
    logic signed [W:0] pos_limit;
    logic signed [W:0] neg_limit;

    // Both operands are sign extended by hand before the add
    assign wide_sum = {a[W-1], a} + {b[W-1], b};

    // Largest positive sample value in the extended width
    assign pos_limit = {2'b00, {(W-1){1'b1}}};

    // Unsigned channels stop at zero instead of the most negative value
    assign neg_limit = signed_mode ? {2'b11, {(W-1){1'b0}}} : '0;

    always_comb begin
        if (wide_sum > pos_limit) begin
            sum = pos_limit[W-1:0];
        end else if (wide_sum < neg_limit) begin
            sum = neg_limit[W-1:0];
        end else begin
            // In range, so dropping the guard bit loses nothing
            sum = wide_sum[W-1:0];
        end
    end

endmodule

//--- tb_calibration.sv
// ======================================================================
// ADC calibration testbench
// Directed tests for the APB register bank and the calibration stream,
// checked against a model of the offset, clamp and shift rules
// ======================================================================
`timescale 1ns/1ps

`include "cal_config.svh"

module tb_calibration
    import cal_stream_pkg::*, cal_regs_pkg::*;
;

    localparam int W = `CAL_SAMPLE_WIDTH;
    localparam int N = `CAL_CHANNELS;
    localparam int TIMEOUT_CYCLES = 4000;

    logic clock;
    logic reset;
    logic psel, penable, pwrite, pready, pslverr;
    apb_addr_t paddr;
    apb_data_t pwdata, prdata;
    logic in_valid, in_ready, out_valid, out_ready;
    sample_t in_data, out_data;
    channel_t in_dest, out_dest;
    user_t in_user, out_user;

    // Shadow copy of the register bank that the model works from
    int model_offset [N];
    int model_shift [N];
    logic [N-1:0] model_signed;
    logic model_shift_en;

    int check_count;
    int error_count;
    int cycle_count;

    calibration_top i_dut (.*);

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("ERR %0t: %s got %h expected %h", $time, what, got, expected);
        end
    endtask

    // Model of the calibration rule that adds, clamps high, clamps low per
    // signedness and then shifts when enabled
    function automatic sample_t expected_output(input sample_t data, input channel_t dest);
        int s;
        int low;
        s = int'(data) + model_offset[dest];
        if (s > (1 << (W - 1)) - 1) s = (1 << (W - 1)) - 1;
        low = model_signed[dest] ? -(1 << (W - 1)) : 0;
        if (s < low) s = low;
        if (model_shift_en) s = s << model_shift[dest];
        return sample_t'(s);
    endfunction

    // Setup on one falling edge, access on the next, sample mid access
    task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
        @(negedge clock);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = 1'b1;
        paddr = addr;
        pwdata = data;
        @(negedge clock);
        penable = 1'b1;
        err = pslverr;
        check_value("pready in write access", 32'(pready), 32'd1);
        @(negedge clock);
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
        @(negedge clock);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = addr;
        @(negedge clock);
        penable = 1'b1;
        // prdata and pslverr were registered at the end of setup
        data = prdata;
        err = pslverr;
        check_value("pready in read access", 32'(pready), 32'd1);
        @(negedge clock);
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic write_register(input apb_addr_t addr, input apb_data_t data);
        logic err;
        apb_write(addr, data, err);
        check_value($sformatf("pslverr on write 0x%02h", addr), 32'(err), 32'd0);
    endtask

    task automatic read_expect(input apb_addr_t addr, input apb_data_t expected);
        apb_data_t data;
        logic err;
        apb_read(addr, data, err);
        check_value($sformatf("pslverr on read 0x%02h", addr), 32'(err), 32'd0);
        check_value($sformatf("read 0x%02h", addr), data, expected);
    endtask

    task automatic set_offset(input int ch, input int value);
        write_register(apb_addr_t'(REG_OFFSET_BASE + 4 * ch), apb_data_t'(value));
        model_offset[ch] = value;
    endtask

    task automatic set_shift(input int ch, input int value);
        write_register(apb_addr_t'(REG_SHIFT_BASE + 4 * ch), apb_data_t'(value));
        model_shift[ch] = value;
    endtask

    task automatic set_ctrl(input logic enable);
        write_register(REG_CTRL, apb_data_t'(enable));
        model_shift_en = enable;
    endtask

    task automatic set_mask(input logic [N-1:0] mask);
        write_register(REG_SIGNED_MASK, apb_data_t'(mask));
        model_signed = mask;
    endtask

    // Compares every register with the shadow copy and expects offsets
    // to come back sign extended
    task automatic read_all_registers;
        read_expect(REG_CTRL, apb_data_t'(model_shift_en));
        read_expect(REG_SIGNED_MASK, apb_data_t'(model_signed));
        for (int ch = 0; ch < N; ch++) begin
            read_expect(apb_addr_t'(REG_OFFSET_BASE + 4 * ch), apb_data_t'(model_offset[ch]));
            read_expect(apb_addr_t'(REG_SHIFT_BASE + 4 * ch), apb_data_t'(model_shift[ch]));
        end
    endtask

    task automatic check_output(input sample_t data, input channel_t dest, input user_t user);
        check_value("out_valid", 32'(out_valid), 32'd1);
        check_value("out_data", 32'(out_data), 32'(data));
        check_value("out_dest", 32'(out_dest), 32'(dest));
        check_value("out_user", 32'(out_user), 32'(user));
    endtask

    // Presents one sample, holds it until accepted, checks the next cycle
    task automatic send_sample(input sample_t data, input channel_t dest, input user_t user);
        sample_t expected;
        expected = expected_output(data, dest);
        @(negedge clock);
        in_valid = 1'b1;
        in_data = data;
        in_dest = dest;
        in_user = user;
        // in_ready only moves on falling edges, so it is stable here
        do @(posedge clock); while (!in_ready);
        @(negedge clock);
        in_valid = 1'b0;
        check_output(expected, dest, user);
    endtask

    function automatic sample_t random_sample(input int span);
        return sample_t'(int'($urandom_range(2 * span)) - span);
    endfunction

    task automatic test_reset_readback;
        read_all_registers();
        set_ctrl(1'($urandom));
        set_mask(N'($urandom));
        for (int ch = 0; ch < N; ch++) begin
            set_offset(ch, int'($urandom_range(65535)) - 32768);
            set_shift(ch, int'($urandom_range(15)));
        end
        read_all_registers();
        set_ctrl(1'b0);
        set_mask('1);
    endtask

    // Offsets and samples are small enough that the sum never clamps
    task automatic test_offset;
        int ch;
        for (int i = 0; i < 20; i++) begin
            ch = int'($urandom_range(N - 1));
            set_offset(ch, int'($urandom_range(2000)) - 1000);
            send_sample(random_sample(20000), channel_t'(ch), user_t'($urandom));
        end
    endtask

    task automatic test_saturation;
        set_offset(0, 30000);
        send_sample(sample_t'(10000), channel_t'(0), 8'h11);
        set_offset(0, -30000);
        send_sample(sample_t'(-10000), channel_t'(0), 8'h22);
        set_offset(1, -100);
        send_sample(sample_t'(50), channel_t'(1), 8'h33);
        // With channel 1 unsigned the same negative sum now stops at zero
        set_mask(model_signed & ~(N'(1) << 1));
        send_sample(sample_t'(50), channel_t'(1), 8'h44);
        send_sample(sample_t'(-32768), channel_t'(1), 8'h55);
        send_sample(sample_t'(250), channel_t'(1), 8'h66);
        set_mask('1);
    endtask

    task automatic test_shift;
        // Channel 0 keeps a zero shift and every other channel shifts by at least one
        for (int ch = 0; ch < N; ch++) begin
            set_offset(ch, int'($urandom_range(200)) - 100);
            set_shift(ch, (ch == 0) ? 0 : 1 + int'($urandom_range(14)));
        end
        set_ctrl(1'b1);
        for (int ch = 0; ch < N; ch++) begin
            send_sample(random_sample(3000), channel_t'(ch), user_t'($urandom));
        end
        set_ctrl(1'b0);
        send_sample(random_sample(3000), channel_t'(N - 1), user_t'($urandom));
    endtask

    task automatic test_backpressure;
        sample_t data;
        channel_t dest;
        user_t user;
        sample_t expected;
        data = random_sample(10000);
        dest = channel_t'($urandom_range(N - 1));
        user = user_t'($urandom);
        expected = expected_output(data, dest);
        @(negedge clock);
        out_ready = 1'b0;
        in_valid = 1'b1;
        in_data = data;
        in_dest = dest;
        in_user = user;
        repeat (4) begin
            @(negedge clock);
            check_value("in_ready during stall", 32'(in_ready), 32'd0);
            check_value("out_valid during stall", 32'(out_valid), 32'd0);
        end
        out_ready = 1'b1;
        @(negedge clock);
        in_valid = 1'b0;
        check_output(expected, dest, user);
        // The held sample must come out once only
        @(negedge clock);
        check_value("out_valid after release", 32'(out_valid), 32'd0);
    endtask

    task automatic test_address_errors;
        apb_addr_t bad_addr [5];
        apb_data_t data;
        logic err;
        bad_addr = '{8'h08, 8'h0C, 8'h11, 8'h30, 8'hFC};
        // A cleared mask shows up if a stray all-ones write lands on it
        set_mask('0);
        foreach (bad_addr[i]) begin
            apb_write(bad_addr[i], 32'hFFFF_FFFF, err);
            check_value($sformatf("pslverr on bad write 0x%02h", bad_addr[i]), 32'(err), 32'd1);
            apb_read(bad_addr[i], data, err);
            check_value($sformatf("pslverr on bad read 0x%02h", bad_addr[i]), 32'(err), 32'd1);
        end
        read_all_registers();
        set_mask('1);
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        void'($urandom(32'h328c));
        check_count = 0;
        error_count = 0;
        reset = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        in_valid = 1'b0;
        in_data = '0;
        in_dest = '0;
        in_user = '0;
        out_ready = 1'b1;
        // Shadow starts at the documented reset values
        model_shift_en = 1'b0;
        model_signed = '1;
        for (int ch = 0; ch < N; ch++) begin
            model_offset[ch] = 0;
            model_shift[ch] = 0;
        end
        repeat (5) @(negedge clock);
        reset = 1'b1;
        test_reset_readback();
        test_offset();
        test_saturation();
        test_shift();
        test_backpressure();
        test_address_errors();
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
